// ==== mapper_settings.svh ====
// ~~~~~~~~~~~~~~~~~~~~
// sizing and timing constants for the memory mapper
// include wherever register counts or cen ratio are needed
// ~~~~~~~~~~~~~~~~~~~~

`ifndef MAPPER_SETTINGS_SVH
`define MAPPER_SETTINGS_SVH

// whole register file, in bytes
`define MAPPER_NUM_REGS 32

// address regions, each one control byte plus one base byte
`define MAPPER_NUM_REGIONS 8

// cpu clock enable ratio, num pulses every den clk cycles
`define MAPPER_CEN_NUM 29
`define MAPPER_CEN_DEN 146

// wait code that hands dtack over to the edack pin
`define MAPPER_WAIT_EXT 3

// byte shared with the sound cpu
`define MAPPER_MAILBOX_REG 3

`endif

// ==== mapper_regs_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// register map types of the mapper
// region control layout and register numbering
// ~~~~~~~~~~~~~~~~~~~~

`include "mapper_settings.svh"

package mapper_regs_pkg;

    // region size codes, 64 kB up to 2 MB
    typedef enum logic [1:0] {
        SIZE_64K  = 2'd0,
        SIZE_128K = 2'd1,
        SIZE_512K = 2'd2,
        SIZE_2M   = 2'd3
    } size_code_e;

    // control byte of one region
    typedef struct packed {
        logic [3:0] rsvd;
        // dtack wait states, 3 means wait for edack
        logic [1:0] wait_code;
        size_code_e size;
    } region_ctrl_t;

    // a stored byte, raw or seen as region control
    typedef union packed {
        logic [7:0]   raw;
        region_ctrl_t ctrl;
    } reg_byte_u;

    // register number inside the file
    typedef logic [$clog2(`MAPPER_NUM_REGS)-1:0] reg_index_t;

endpackage

// ==== mapper_bus_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// 68000 bus bundle and region selection result
// shared by the decoder, timer and interrupt blocks
// ~~~~~~~~~~~~~~~~~~~~

`include "mapper_settings.svh"

package mapper_bus_pkg;

    // one 68000 bus snapshot, strobes active low
    typedef struct packed {
        logic [23:1] addr;
        logic [15:0] wdata;
        logic [1:0]  dsn;
        logic [1:0]  dswn;
        logic        asn;
        logic [2:0]  fc;
    } cpu_bus_t;

    // decoder output
    typedef struct packed {
        // one-hot, all zero when nothing matches
        logic [`MAPPER_NUM_REGIONS-1:0] active;
        logic [1:0]                     wait_code;
    } region_sel_t;

endpackage

// ==== region_decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// priority region match of the cpu address
// purely combinational, region 0 wins over the rest
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "mapper_settings.svh"

module region_decoder (
    input  mapper_bus_pkg::cpu_bus_t                              cpu,
    input  mapper_regs_pkg::reg_byte_u [2*`MAPPER_NUM_REGIONS-1:0] regions,
    output mapper_bus_pkg::region_sel_t                           sel
);

    always_comb begin
        logic                          hit;
        mapper_regs_pkg::region_ctrl_t ctrl;
        logic [7:0]                    base;

        hit  = 1'b0;
        ctrl = '0;
        base = '0;
        sel  = '0;
        for (int r = 0; r < `MAPPER_NUM_REGIONS; r++) begin
            // even byte is control, odd byte is base
            ctrl = regions[2*r].ctrl;
            base = regions[2*r+1].raw;
            hit  = 1'b0;
            // bigger regions compare fewer top bits
            case (ctrl.size)
                mapper_regs_pkg::SIZE_64K:  hit = cpu.addr[23:16] == base;
                mapper_regs_pkg::SIZE_128K: hit = cpu.addr[23:17] == base[7:1];
                mapper_regs_pkg::SIZE_512K: hit = cpu.addr[23:19] == base[7:3];
                mapper_regs_pkg::SIZE_2M:   hit = cpu.addr[23:21] == base[7:5];
                default:                    hit = 1'b0;
            endcase
            // first match only
            if (hit && sel.active == '0) begin
                sel.active[r] = 1'b1;
                sel.wait_code = ctrl.wait_code;
            end
        end
        // interrupt acknowledge is not a memory access
        if (cpu.fc == 3'b111) begin
            sel = '0;
        end
    end

endmodule

// ==== mapper_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// mapper register file with cpu or mcu ownership
// also drives the sound cpu mailbox and its full flag
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "mapper_settings.svh"

module mapper_regs (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  mapper_bus_pkg::cpu_bus_t                              cpu,
    input  logic                                                  none_active,
    input  logic                                                  mcu_wr,
    input  logic [4:0]                                            mcu_addr,
    input  logic [7:0]                                            mcu_dout,
    output logic [7:0]                                            mcu_din,
    input  logic                                                  sndmap_rd,
    output logic [7:0]                                            sndmap_dout,
    output logic                                                  sndmap_obf,
    output mapper_regs_pkg::reg_byte_u [2*`MAPPER_NUM_REGIONS-1:0] regions
);

    // region bytes sit at the top of the file
    localparam int REGION_BASE = `MAPPER_NUM_REGS - 2*`MAPPER_NUM_REGIONS;

    logic [7:0]                  mem [`MAPPER_NUM_REGS];
    // cleared by the first mcu write, only reset sets it again
    logic                        cpu_owner;
    logic                        cpu_wr;
    logic                        wr_en;
    mapper_regs_pkg::reg_index_t wr_idx;
    logic [7:0]                  wr_data;

    // cpu writes only outside mapped regions, low byte lane
    assign cpu_wr  = cpu_owner & ~mcu_wr & ~cpu.asn & ~cpu.dswn[0] & none_active;
    // an mcu write always lands, it claims the file in the same cycle
    assign wr_en   = cpu_wr | mcu_wr;
    assign wr_idx  = mcu_wr ? mcu_addr : cpu.addr[5:1];
    assign wr_data = mcu_wr ? mcu_dout : cpu.wdata[7:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MAPPER_NUM_REGS; i++) begin
                mem[i] <= '0;
            end
            cpu_owner  <= 1'b1;
            sndmap_obf <= 1'b0;
        end else begin
            if (mcu_wr) begin
                cpu_owner <= 1'b0;
            end
            if (wr_en) begin
                mem[wr_idx] <= wr_data;
                if (wr_idx == `MAPPER_MAILBOX_REG) begin
                    sndmap_obf <= 1'b1;
                end
            end
            // read beats a same-cycle write
            if (sndmap_rd) begin
                sndmap_obf <= 1'b0;
            end
        end
    end

    assign mcu_din     = mem[mcu_addr];
    assign sndmap_dout = mem[`MAPPER_MAILBOX_REG];

    // control and base bytes for the decoder
    always_comb begin
        for (int r = 0; r < 2*`MAPPER_NUM_REGIONS; r++) begin
            regions[r].raw = mem[REGION_BASE + r];
        end
    end

endmodule

// ==== dtack_timer.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// fractional cpu clock enable and dtack wait states
// wait code comes from the selected region
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "mapper_settings.svh"

module dtack_timer (
    input  logic                     clk,
    input  logic                     rst,
    input  mapper_bus_pkg::cpu_bus_t cpu,
    input  logic [1:0]               wait_code,
    input  logic                     edack,
    output logic                     cpu_cen,
    output logic                     cpu_dtackn
);

    logic [7:0] acc;
    logic [8:0] acc_sum;
    // cen pulses seen in this bus cycle
    logic [1:0] cen_cnt;
    logic       dtackn_q;
    logic       bus_n;

    // cycle runs while as and a data strobe are low
    assign bus_n   = cpu.asn | (&cpu.dsn);
    assign acc_sum = {1'b0, acc} + 9'(`MAPPER_CEN_NUM);

    // num/den below one half, so pulses never touch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc     <= '0;
            cpu_cen <= 1'b0;
        end else if (acc_sum >= 9'(`MAPPER_CEN_DEN)) begin
            acc     <= 8'(acc_sum - 9'(`MAPPER_CEN_DEN));
            cpu_cen <= 1'b1;
        end else begin
            acc     <= acc_sum[7:0];
            cpu_cen <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dtackn_q <= 1'b1;
            cen_cnt  <= '0;
        end else if (cpu.asn) begin
            // end of cycle, rearm
            dtackn_q <= 1'b1;
            cen_cnt  <= '0;
        end else if (!bus_n && cpu_cen && dtackn_q) begin
            if (wait_code == 2'(`MAPPER_WAIT_EXT)) begin
                // external device decides
                if (edack) begin
                    dtackn_q <= 1'b0;
                end
            end else if (cen_cnt == wait_code) begin
                dtackn_q <= 1'b0;
            end else begin
                cen_cnt <= cen_cnt + 2'd1;
            end
        end
    end

    // released as soon as the strobe goes away
    assign cpu_dtackn = dtackn_q | cpu.asn;

endmodule

// ==== vblank_irq.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// vblank interrupt to the 68000
// set on vint rising edge, cleared by acknowledge
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vblank_irq (
    input  logic                     clk,
    input  logic                     rst,
    input  mapper_bus_pkg::cpu_bus_t cpu,
    input  logic                     vint,
    output logic [2:0]               cpu_ipln,
    output logic                     cpu_vpan
);

    logic vint_l;
    logic irqn;
    // acknowledge is fc 7 with as low
    logic inta_n;

    assign inta_n = ~((&cpu.fc) & ~cpu.asn);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vint_l <= 1'b0;
            irqn   <= 1'b1;
        end else begin
            vint_l <= vint;
            // ack has priority over a new edge
            if (!inta_n) begin
                irqn <= 1'b1;
            end else if (vint && !vint_l) begin
                irqn <= 1'b0;
            end
        end
    end

    // autovector during acknowledge
    assign cpu_vpan = inta_n;
    // level 4 line only
    assign cpu_ipln = {irqn, 2'b11};

endmodule

// ==== s16_mapper.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// 68000 memory mapper top
// joins decoder, registers, dtack timer and interrupt
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "mapper_settings.svh"

module s16_mapper (
    input  logic                          clk,
    input  logic                          rst,
    input  mapper_bus_pkg::cpu_bus_t      cpu,
    input  logic                          edack,
    input  logic                          vint,
    // mcu port
    input  logic                          mcu_wr,
    input  logic [4:0]                    mcu_addr,
    input  logic [7:0]                    mcu_dout,
    output logic [7:0]                    mcu_din,
    // sound cpu port
    input  logic                          sndmap_rd,
    output logic [7:0]                    sndmap_dout,
    output logic                          sndmap_obf,
    output logic [`MAPPER_NUM_REGIONS-1:0] active,
    output logic                          cpu_cen,
    output logic                          cpu_dtackn,
    output logic [2:0]                    cpu_ipln,
    output logic                          cpu_vpan
);

    mapper_bus_pkg::region_sel_t                           sel;
    mapper_regs_pkg::reg_byte_u [2*`MAPPER_NUM_REGIONS-1:0] regions;
    logic                                                  none_active;

    assign active      = sel.active;
    assign none_active = ~|sel.active;

    region_decoder i_decoder (
        .cpu     (cpu),
        .regions (regions),
        .sel     (sel)
    );

    mapper_regs i_regs (
        .clk         (clk),
        .rst         (rst),
        .cpu         (cpu),
        .none_active (none_active),
        .mcu_wr      (mcu_wr),
        .mcu_addr    (mcu_addr),
        .mcu_dout    (mcu_dout),
        .mcu_din     (mcu_din),
        .sndmap_rd   (sndmap_rd),
        .sndmap_dout (sndmap_dout),
        .sndmap_obf  (sndmap_obf),
        .regions     (regions)
    );

    dtack_timer i_dtack (
        .clk        (clk),
        .rst        (rst),
        .cpu        (cpu),
        .wait_code  (sel.wait_code),
        .edack      (edack),
        .cpu_cen    (cpu_cen),
        .cpu_dtackn (cpu_dtackn)
    );

    vblank_irq i_irq (
        .clk      (clk),
        .rst      (rst),
        .cpu      (cpu),
        .vint     (vint),
        .cpu_ipln (cpu_ipln),
        .cpu_vpan (cpu_vpan)
    );

endmodule

// ==== s16_mapper_chk.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// protocol assertions on the mapper top
// bound to the DUT from the testbench
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module s16_mapper_chk (
    input logic                     clk,
    input logic                     rst,
    input mapper_bus_pkg::cpu_bus_t cpu,
    input logic                     cpu_cen,
    input logic                     cpu_dtackn,
    input logic                     cpu_vpan
);

    // assertion failures so far
    int fail_count = 0;

    // dtack only inside a bus cycle
    dtack_idle: assert property (@(posedge clk) disable iff (rst)
        cpu.asn |-> cpu_dtackn)
        else begin
            $error("dtack low while the address strobe is high");
            fail_count++;
        end

    // cen is a lone pulse
    cen_single: assert property (@(posedge clk) disable iff (rst)
        cpu_cen |=> !cpu_cen)
        else begin
            $error("cpu_cen high two cycles in a row");
            fail_count++;
        end

    // autovector only in acknowledge
    vpan_ack: assert property (@(posedge clk) disable iff (rst)
        !cpu_vpan |-> cpu.fc == 3'b111)
        else begin
            $error("cpu_vpan low outside interrupt acknowledge");
            fail_count++;
        end

endmodule

// ==== s16_mapper_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// testbench for the 68000 memory mapper
// replays the golden command file against the DUT
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "mapper_settings.svh"

module s16_mapper_tb;

    logic                           clk;
    logic                           rst;
    mapper_bus_pkg::cpu_bus_t       cpu;
    logic                           edack;
    logic                           vint;
    logic                           mcu_wr;
    logic [4:0]                     mcu_addr;
    logic [7:0]                     mcu_dout;
    logic [7:0]                     mcu_din;
    logic                           sndmap_rd;
    logic [7:0]                     sndmap_dout;
    logic                           sndmap_obf;
    logic [`MAPPER_NUM_REGIONS-1:0] active;
    logic                           cpu_cen;
    logic                           cpu_dtackn;
    logic [2:0]                     cpu_ipln;
    logic                           cpu_vpan;

    int errors;
    int test_errors;
    int tests;

    s16_mapper i_dut (.*);

    bind s16_mapper s16_mapper_chk i_chk (
        .clk        (clk),
        .rst        (rst),
        .cpu        (cpu),
        .cpu_cen    (cpu_cen),
        .cpu_dtackn (cpu_dtackn),
        .cpu_vpan   (cpu_vpan)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // bus at rest, all strobes high
    function automatic mapper_bus_pkg::cpu_bus_t idle_bus();
        mapper_bus_pkg::cpu_bus_t b;
        b      = '0;
        b.dsn  = 2'b11;
        b.dswn = 2'b11;
        b.asn  = 1'b1;
        b.fc   = 3'b101;
        return b;
    endfunction

    task automatic compare_value(input string name, input logic [7:0] got,
                                 input logic [7:0] exp);
        assert (got === exp) else begin
            $display("error %s got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string desc);
        tests++;
        errors += test_errors;
        $display("test %0d %s: %s", tests, desc, (test_errors == 0) ? "ok" : "fail");
        test_errors = 0;
    endtask

    // low byte write into the unmapped ff page, then read back through mcu_din
    task automatic cpu_write(input logic [4:0] idx, input logic [7:0] data,
                             input logic [7:0] exp);
        @(posedge clk);
        cpu.addr  <= {8'hff, 10'h000, idx};
        cpu.wdata <= {8'h00, data};
        cpu.asn   <= 1'b0;
        cpu.dswn  <= 2'b10;
        mcu_addr  <= idx;
        @(posedge clk);
        cpu       <= idle_bus();
        @(negedge clk);
        compare_value("mcu_din", mcu_din, exp);
    endtask

    task automatic mcu_write(input logic [4:0] idx, input logic [7:0] data,
                             input logic [7:0] exp);
        @(posedge clk);
        mcu_wr   <= 1'b1;
        mcu_addr <= idx;
        mcu_dout <= data;
        @(posedge clk);
        mcu_wr   <= 1'b0;
        @(negedge clk);
        compare_value("mcu_din", mcu_din, exp);
    endtask

    // address only, strobes stay high
    task automatic probe_address(input logic [23:0] addr, input logic [2:0] fc,
                                 input logic [7:0] exp);
        @(posedge clk);
        cpu.addr <= addr[23:1];
        cpu.fc   <= fc;
        @(negedge clk);
        compare_value("active", active, exp);
        @(posedge clk);
        cpu      <= idle_bus();
    endtask

    // read cycle, edack rises once edack_after cen pulses were seen
    task automatic bus_cycle(input logic [23:0] addr, input int edack_after,
                             input logic [7:0] exp);
        int count;
        int cycles;
        count  = 0;
        cycles = 0;
        @(posedge clk);
        cpu.addr <= addr[23:1];
        cpu.asn  <= 1'b0;
        cpu.dsn  <= 2'b00;
        edack    <= (edack_after == 0);
        @(negedge clk);
        while (cpu_dtackn && cycles < 200) begin
            if (cpu_cen) begin
                count++;
            end
            @(posedge clk);
            edack <= (count >= edack_after);
            @(negedge clk);
            cycles++;
        end
        if (cpu_dtackn) begin
            $display("dtack never went low for address %h", addr);
            test_errors++;
        end else begin
            compare_value("cen_count", 8'(count), exp);
        end
        @(posedge clk);
        cpu   <= idle_bus();
        edack <= 1'b0;
        @(negedge clk);
        compare_value("cpu_dtackn", 8'(cpu_dtackn), 8'h01);
    endtask

    task automatic vblank_pulse();
        int cycles;
        cycles = 0;
        @(posedge clk);
        vint <= 1'b1;
        @(negedge clk);
        while (cpu_ipln[2] && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        if (cpu_ipln[2]) begin
            $display("interrupt never asserted after the vblank edge");
            test_errors++;
        end
        compare_value("cpu_ipln", 8'(cpu_ipln), 8'h03);
        compare_value("cpu_vpan", 8'(cpu_vpan), 8'h01);
        @(posedge clk);
        vint <= 1'b0;
    endtask

    task automatic interrupt_ack();
        int cycles;
        cycles = 0;
        @(posedge clk);
        cpu.fc  <= 3'b111;
        cpu.asn <= 1'b0;
        @(negedge clk);
        // autovector and no region during ack
        compare_value("cpu_vpan", 8'(cpu_vpan), 8'h00);
        compare_value("active", active, 8'h00);
        while (!cpu_ipln[2] && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        if (!cpu_ipln[2]) begin
            $display("interrupt still pending after acknowledge");
            test_errors++;
        end
        compare_value("cpu_ipln", 8'(cpu_ipln), 8'h07);
        @(posedge clk);
        cpu <= idle_bus();
        @(negedge clk);
        compare_value("cpu_vpan", 8'(cpu_vpan), 8'h01);
    endtask

    task automatic sound_read(input logic [7:0] exp);
        @(negedge clk);
        compare_value("sndmap_obf", 8'(sndmap_obf), 8'h01);
        compare_value("sndmap_dout", sndmap_dout, exp);
        @(posedge clk);
        sndmap_rd <= 1'b1;
        @(posedge clk);
        sndmap_rd <= 1'b0;
        @(negedge clk);
        compare_value("sndmap_obf", 8'(sndmap_obf), 8'h00);
    endtask

    initial begin
        int            fd;
        int            code;
        logic [7:0]    cmd;
        logic [23:0]   op_a;
        logic [7:0]    op_b;
        logic [7:0]    op_c;
        logic [1023:0] skip;
        errors      = 0;
        test_errors = 0;
        tests       = 0;
        rst         = 1'b1;
        cpu         = idle_bus();
        edack       = 1'b0;
        vint        = 1'b0;
        mcu_wr      = 1'b0;
        mcu_addr    = '0;
        mcu_dout    = '0;
        sndmap_rd   = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        // state straight out of reset
        compare_value("cpu_dtackn", 8'(cpu_dtackn), 8'h01);
        compare_value("cpu_ipln", 8'(cpu_ipln), 8'h07);
        compare_value("cpu_vpan", 8'(cpu_vpan), 8'h01);
        compare_value("sndmap_obf", 8'(sndmap_obf), 8'h00);
        compare_value("mcu_din", mcu_din, 8'h00);
        finish_test("reset");
        fd = $fopen("s16_mapper_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file");
            errors++;
        end else begin
            code = $fscanf(fd, " %c", cmd);
            while (code == 1) begin
                if (cmd == "#") begin
                    code = $fgets(skip, fd);
                end else begin
                    code = $fscanf(fd, " %h %h %h", op_a, op_b, op_c);
                    if (code != 3) begin
                        $display("golden line for command %c is malformed", cmd);
                        test_errors++;
                    end else begin
                        case (cmd)
                            "W": cpu_write(op_a[4:0], op_b, op_c);
                            "M": mcu_write(op_a[4:0], op_b, op_c);
                            "A": probe_address(op_a, op_b[2:0], op_c);
                            "D": bus_cycle(op_a, int'(op_b), op_c);
                            "V": vblank_pulse();
                            "K": interrupt_ack();
                            "S": sound_read(op_c);
                            default: begin
                                $display("unknown golden command %c", cmd);
                                test_errors++;
                            end
                        endcase
                    end
                    finish_test($sformatf("%c %h %h %h", cmd, op_a, op_b, op_c));
                end
                code = $fscanf(fd, " %c", cmd);
            end
            $fclose(fd);
        end
        // protocol assertions bound into the DUT
        if (i_dut.i_chk.fail_count != 0) begin
            $display("bound protocol assertions failed %0d times", i_dut.i_chk.fail_count);
            errors += i_dut.i_chk.fail_count;
        end
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== s16_mapper_golden.txt ====
# cmd a b c in hex: W/M reg data readback, A addr fc active, D addr edack_after cen_count
# V and K take 0 0 0, S takes 0 0 mailbox_byte
# region 0, 64 kB at 20, wait 0
W 10 00 00
W 11 20 20
# region 1, 2 MB at 20, wait 1
W 12 07 07
W 13 20 20
# region 2, 512 kB at 40, wait 2
W 14 0a 0a
W 15 40 40
# region 3, 128 kB at 60, wait external
W 16 0d 0d
W 17 60 60
# region 4, 64 kB at 41, hidden under region 2
W 19 41 41
A 201000 5 01
A 210000 5 02
A 3ffffe 5 02
A 410000 5 04
A 47fffe 5 04
A 480000 5 00
A 600000 5 08
A 620000 5 00
A 001234 5 20
A 201000 7 00
D 201000 0 1
D 300000 0 2
D 400000 0 3
D 600000 4 5
D ff0000 0 1
W 03 5a 5a
S 0 0 5a
W 03 11 11
W 03 c3 c3
S 0 0 c3
V 0 0 0
K 0 0 0
# mcu takes over, cpu writes are dropped
M 15 48 48
W 15 40 48
W 03 77 c3
A 480000 5 04
A 410000 5 10
M 10 08 08
D 201000 0 3

// ==== s16_mapper.f ====
+incdir+.
mapper_regs_pkg.sv
mapper_bus_pkg.sv
region_decoder.sv
mapper_regs.sv
dtack_timer.sv
vblank_irq.sv
s16_mapper.sv
s16_mapper_chk.sv
s16_mapper_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the mapper testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f s16_mapper.f --top-module s16_mapper_tb \
    && ./obj_dir/Vs16_mapper_tb | tee /dev/stderr | grep -x "Result: PASSED" > /dev/null \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }
